// ==== rtl/mem_pkg.sv ====
// Register file geometry
package mem_pkg;

    // array shape, fixed for the whole design
    localparam int unsigned MEM_DW    = 16;
    localparam int unsigned MEM_AW    = 4;
    localparam int unsigned MEM_DEPTH = 2 ** MEM_AW;  // one entry per address

    typedef logic [MEM_DW-1:0] word_t;
    typedef logic [MEM_AW-1:0] addr_t;

    // one access to the array, from either the host or the self-test side
    typedef struct packed {
        logic  we;     // write strobe, read happens every cycle regardless
        addr_t addr;
        word_t wdata;
    } mem_req_t;

endpackage

// ==== rtl/bist_pkg.sv ====
// Self-test control types
package bist_pkg;

    // controller phases, IDLE means the host owns the array
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        WRITE  = 3'd1,   // fill every entry with its pattern
        READ   = 3'd2,   // read back, compares trail by one cycle
        DRAIN  = 3'd3,   // finishes the last compare
        REPAIR = 3'd4    // rewrite the pattern before handing back
    } bist_phase_e;

    // what the controller tells the datapath each cycle
    typedef struct packed {
        bist_phase_e    phase;
        mem_pkg::addr_t addr;   // entry the self-test is working on
    } bist_ctrl_t;

endpackage

// ==== rtl/bist_addr_counter.sv ====
// Self-test address counter
`timescale 1ns/1ps

module bist_addr_counter (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           clr,
    input  logic           en,
    output mem_pkg::addr_t addr,
    output logic           last
);
    import mem_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr <= '0;
        end else if (clr) begin
            addr <= '0;  // clear wins over a concurrent step
        end else if (en) begin
            addr <= addr + 1'b1;  // wraps naturally at the depth
        end
    end

    assign last = (addr == addr_t'(MEM_DEPTH - 1));

endmodule

// ==== rtl/bist_fsm.sv ====
// Self-test controller
`timescale 1ns/1ps

module bist_fsm (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_test,
    input  logic                 last,
    output logic                 cnt_clr,
    output logic                 cnt_en,
    output bist_pkg::bist_ctrl_t ctrl,
    input  mem_pkg::addr_t       cnt_addr,
    output logic                 bist_active,
    output logic                 test_done
);
    import bist_pkg::*;

    bist_phase_e phase;
    bist_phase_e phase_nxt;
    logic        counting;

    // the three phases that sweep all entries
    assign counting = (phase == WRITE) || (phase == READ) || (phase == REPAIR);

    always_comb begin
        phase_nxt = phase;
        case (phase)
            IDLE: begin
                if (start_test) begin
                    phase_nxt = WRITE;  // a start while busy never reaches here
                end
            end
            WRITE: begin
                if (last) begin
                    phase_nxt = READ;
                end
            end
            READ: begin
                if (last) begin
                    phase_nxt = DRAIN;
                end
            end
            DRAIN: begin
                phase_nxt = REPAIR;  // one cycle for the trailing compare
            end
            REPAIR: begin
                if (last) begin
                    phase_nxt = IDLE;
                end
            end
            default: begin
                phase_nxt = IDLE;
            end
        endcase
    end

    // each phase starts its sweep from entry zero
    assign cnt_clr = (phase_nxt != phase);
    assign cnt_en  = counting;

    assign ctrl = '{phase: phase, addr: cnt_addr};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase       <= IDLE;
            bist_active <= 1'b0;
            test_done   <= 1'b1;  // nothing pending out of reset
        end else begin
            phase       <= phase_nxt;
            bist_active <= (phase_nxt != IDLE);
            test_done   <= (phase_nxt == IDLE);
        end
    end

endmodule

// ==== rtl/regfile_array.sv ====
// Register file storage array
`timescale 1ns/1ps

module regfile_array (
    input  logic                 clk,
    input  logic                 rst_n,
    input  bist_pkg::bist_ctrl_t ctrl,
    input  mem_pkg::mem_req_t    host_req,
    input  mem_pkg::mem_req_t    bist_req,
    output mem_pkg::word_t       rdata
);
    import mem_pkg::*;
    import bist_pkg::*;

    word_t    mem [MEM_DEPTH];
    mem_req_t sel_req;

    // host writes during a test are dropped here
    assign sel_req = (ctrl.phase == IDLE) ? host_req : bist_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else begin
            if (sel_req.we) begin
                mem[sel_req.addr] <= sel_req.wdata;
            end
            rdata <= mem[sel_req.addr];  // same-cycle write shows up a cycle later
        end
    end

endmodule

// ==== rtl/bist_checker.sv ====
// Self-test pattern and compare
`timescale 1ns/1ps

module bist_checker #(
    parameter mem_pkg::word_t PATTERN0 = 16'hAAAA,
    parameter mem_pkg::word_t PATTERN1 = 16'h5555,
    parameter int unsigned    ERR_W    = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  bist_pkg::bist_ctrl_t ctrl,
    input  logic                 start,
    input  mem_pkg::word_t       rdata,
    output mem_pkg::mem_req_t    bist_req,
    output logic [ERR_W-1:0]     error_count
);
    import mem_pkg::*;
    import bist_pkg::*;

    word_t pattern;
    word_t exp_word;
    logic  exp_vld;
    logic  mismatch;

    // checkerboard split on the top address bit
    assign pattern = ctrl.addr[MEM_AW-1] ? PATTERN1 : PATTERN0;

    assign bist_req.we    = (ctrl.phase == WRITE) || (ctrl.phase == REPAIR);
    assign bist_req.addr  = ctrl.addr;
    assign bist_req.wdata = pattern;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_vld <= 1'b0;
        end else begin
            exp_vld <= (ctrl.phase == READ);  // lines up with the registered rdata
        end
    end

    always_ff @(posedge clk) begin
        exp_word <= pattern;
    end

    assign mismatch = exp_vld && (rdata != exp_word);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            error_count <= '0;
        end else if (start) begin
            error_count <= '0;
        end else if (mismatch && (error_count != '1)) begin
            error_count <= error_count + 1'b1;  // sticks at all ones
        end
    end

endmodule

// ==== rtl/bist_regfile_top.sv ====
// Self-testing register file
`timescale 1ns/1ps

module bist_regfile_top #(
    parameter mem_pkg::word_t PATTERN0 = 16'hAAAA,
    parameter mem_pkg::word_t PATTERN1 = 16'h5555,
    parameter int unsigned    ERR_W    = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start_test,
    input  logic             normal_wr_en,
    input  mem_pkg::addr_t   addr,
    input  mem_pkg::word_t   din,
    output mem_pkg::word_t   dout,
    output logic             test_done,
    output logic             bist_active,
    output logic [ERR_W-1:0] error_count
);
    import mem_pkg::*;
    import bist_pkg::*;

    bist_ctrl_t ctrl;
    mem_req_t   host_req;
    mem_req_t   bist_req;
    addr_t      cnt_addr;
    logic       cnt_clr;
    logic       cnt_en;
    logic       cnt_last;
    logic       start_acc;

    assign host_req = '{we: normal_wr_en, addr: addr, wdata: din};

    // a start only counts when the controller is idle
    assign start_acc = start_test && (ctrl.phase == IDLE);

    bist_fsm i_bist_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_test  (start_test),
        .last        (cnt_last),
        .cnt_clr     (cnt_clr),
        .cnt_en      (cnt_en),
        .ctrl        (ctrl),
        .cnt_addr    (cnt_addr),
        .bist_active (bist_active),
        .test_done   (test_done)
    );

    bist_addr_counter i_bist_addr_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .clr   (cnt_clr),
        .en    (cnt_en),
        .addr  (cnt_addr),
        .last  (cnt_last)
    );

    regfile_array i_regfile_array (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl     (ctrl),
        .host_req (host_req),
        .bist_req (bist_req),
        .rdata    (dout)
    );

    bist_checker #(
        .PATTERN0 (PATTERN0),
        .PATTERN1 (PATTERN1),
        .ERR_W    (ERR_W)
    ) i_bist_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctrl        (ctrl),
        .start       (start_acc),
        .rdata       (dout),
        .bist_req    (bist_req),
        .error_count (error_count)
    );

endmodule

// ==== dv/tb_bist_regfile.sv ====
// Self-test register file testbench
`timescale 1ns/1ps

module tb_bist_regfile;
    import mem_pkg::*;

    localparam word_t       PATTERN0    = 16'hC33C;
    localparam word_t       PATTERN1    = 16'h3CC3;
    localparam int unsigned ERR_W       = 8;
    localparam int          BIST_CYCLES = 3 * MEM_DEPTH + 2;  // start edge to test_done
    localparam int          N_RANDOM    = 20;
    localparam int          RUN_CYCLES  = 4 * (BIST_CYCLES + 1) + 6 * (2 * MEM_DEPTH)
                                          + 2 * N_RANDOM + 32;

    logic             clk;
    logic             rst_n;
    logic             start_test;
    logic             normal_wr_en;
    addr_t            addr;
    word_t            din;
    word_t            dout;
    logic             test_done;
    logic             bist_active;
    logic [ERR_W-1:0] error_count;

    word_t sb [MEM_DEPTH];  // what the register file should hold
    string cur_test;
    int    check_errors;
    int    test_start_errors;
    int    tests_run;
    int    tests_failed;

    bist_regfile_top #(
        .PATTERN0 (PATTERN0),
        .PATTERN1 (PATTERN1),
        .ERR_W    (ERR_W)
    ) i_bist_regfile_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_test   (start_test),
        .normal_wr_en (normal_wr_en),
        .addr         (addr),
        .din          (din),
        .dout         (dout),
        .test_done    (test_done),
        .bist_active  (bist_active),
        .error_count  (error_count)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // the two status levels are complements outside reset
    assert property (@(posedge clk) disable iff (!rst_n) bist_active != test_done)
        else begin
            check_errors++;
            $display("bist_active and test_done were equal at %0t", $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n) !bist_active |-> $stable(error_count))
        else begin
            check_errors++;
            $display("error_count changed while no test was running at %0t", $time);
        end

    function automatic word_t pattern_for(addr_t a);
        return (a < MEM_DEPTH / 2) ? PATTERN0 : PATTERN1;  // upper half holds PATTERN1
    endfunction

    task automatic expect_word(string what, word_t exp, word_t act);
        assert (act === exp) else begin
            check_errors++;
            $display("ERROR %s %s expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic expect_flag(string what, logic exp, logic act);
        assert (act === exp) else begin
            check_errors++;
            $display("ERROR %s %s expected %b actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic expect_count(string what, logic [ERR_W-1:0] exp, logic [ERR_W-1:0] act);
        assert (act === exp) else begin
            check_errors++;
            $display("ERROR %s %s expected %0d actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic expect_cycles(string what, int exp, int act);
        assert (act == exp) else begin
            check_errors++;
            $display("ERROR %s %s expected %0d actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic begin_test(string name);
        cur_test          = name;
        test_start_errors = check_errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (check_errors != test_start_errors) begin
            tests_failed++;
            $display("test %s failed with %0d errors", cur_test, check_errors - test_start_errors);
        end else begin
            $display("test %s passed", cur_test);
        end
    endtask

    // the write strobe stays high until the next access drops it
    task automatic write_word(addr_t a, word_t d);
        @(posedge clk);
        normal_wr_en <= 1'b1;
        addr         <= a;
        din          <= d;
        sb[a] = d;
    endtask

    task automatic read_check(addr_t a);
        @(posedge clk);
        normal_wr_en <= 1'b0;
        addr         <= a;
        @(posedge clk);
        @(negedge clk);
        expect_word($sformatf("read of %h", a), sb[a], dout);
    endtask

    task automatic read_all();
        for (int i = 0; i < MEM_DEPTH; i++) begin
            read_check(addr_t'(i));
        end
    endtask

    task automatic write_read_same(addr_t a, word_t d);
        @(posedge clk);
        normal_wr_en <= 1'b1;
        addr         <= a;
        din          <= d;
        @(posedge clk);
        normal_wr_en <= 1'b0;
        @(negedge clk);
        expect_word($sformatf("read during write of %h", a), sb[a], dout);
        sb[a] = d;
    endtask

    task automatic run_bist(bit disturb);
        int cycles;
        bit done_seen;
        cycles    = 0;
        done_seen = 1'b0;
        @(posedge clk);
        start_test   <= 1'b1;
        normal_wr_en <= 1'b0;
        while (!done_seen && cycles < 2 * BIST_CYCLES) begin
            @(posedge clk);
            cycles++;
            start_test   <= disturb && (cycles == 20);  // second start lands in READ
            normal_wr_en <= disturb && (cycles < 45) && (cycles % 5 == 2);
            addr         <= addr_t'($urandom);
            din          <= word_t'($urandom);
            @(negedge clk);
            if (test_done) begin
                done_seen = 1'b1;
            end else begin
                expect_flag("bist_active while running", 1'b1, bist_active);
            end
        end
        assert (done_seen) else begin
            check_errors++;
            $display("%s: test_done did not rise within %0d cycles of start", cur_test, cycles);
        end
        if (done_seen) begin
            expect_cycles("cycles to test_done", BIST_CYCLES, cycles);
            expect_flag("bist_active after done", 1'b0, bist_active);
            expect_count("error_count after test", '0, error_count);
        end
        for (int i = 0; i < MEM_DEPTH; i++) begin
            sb[i] = pattern_for(addr_t'(i));
        end
    endtask

    initial begin
        void'($urandom(81));
        rst_n        <= 1'b0;
        start_test   <= 1'b0;
        normal_wr_en <= 1'b0;
        addr         <= '0;
        din          <= '0;
        check_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            sb[i] = '0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        begin_test("reset_values");
        expect_flag("test_done", 1'b1, test_done);
        expect_flag("bist_active", 1'b0, bist_active);
        expect_count("error_count", '0, error_count);
        expect_word("dout", '0, dout);
        read_all();
        end_test();

        begin_test("normal_access");
        for (int i = 0; i < N_RANDOM; i++) begin
            write_word(addr_t'($urandom), word_t'($urandom));
        end
        read_all();
        for (int i = 0; i < 4; i++) begin
            write_read_same(addr_t'(4 * i + 2), word_t'($urandom));
            read_check(addr_t'(4 * i + 2));  // the new word is there one access later
        end
        end_test();

        begin_test("bist_timing");
        run_bist(1'b0);
        end_test();

        begin_test("isolation");
        run_bist(1'b1);
        read_all();
        end_test();

        begin_test("repair_contents");
        for (int i = 0; i < N_RANDOM; i++) begin
            write_word(addr_t'($urandom), word_t'($urandom));
        end
        run_bist(1'b0);
        read_all();
        end_test();

        begin_test("clear_repeat");
        for (int i = 0; i < 4; i++) begin
            write_word(addr_t'(3 * i + 1), word_t'($urandom));
        end
        read_all();
        run_bist(1'b0);
        read_all();
        end_test();

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, check_errors);
        if (tests_failed == 0 && check_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // twice the expected run length before giving up
    initial begin
        repeat (2 * RUN_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", 2 * RUN_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== all.f ====
rtl/mem_pkg.sv
rtl/bist_pkg.sv
rtl/bist_addr_counter.sv
rtl/bist_fsm.sv
rtl/regfile_array.sv
rtl/bist_checker.sv
rtl/bist_regfile_top.sv
dv/tb_bist_regfile.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_bist_regfile
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
